// ==== src/mrdma_defines.svh ====
/*
 * mrdma ingress shared constants
 * address widths, cube dimension widths, counter
 * widths and input precision codes for the read DMA
 */

`ifndef MRDMA_DEFINES_SVH
`define MRDMA_DEFINES_SVH

// 32-byte atom, low address bits dropped
`define MRDMA_ATOM_SHIFT 5

// full byte address
`define MRDMA_ADDR_W 32
// atom aligned address
`define MRDMA_ATOM_ADDR_W 27

// width, height, channel fields
`define MRDMA_DIM_W 13
// channel group count
`define MRDMA_CGRP_W 9
// request size, in atoms
`define MRDMA_SIZE_W 15

// perf counter
`define MRDMA_STALL_W 32

// in_precision encodings
`define MRDMA_PREC_INT8 2'd0
`define MRDMA_PREC_INT16 2'd1

`endif

// ==== src/mrdma_pkg.sv ====
/*
 * mrdma ingress types
 * register configuration of one operation, the DMA
 * read request payload and the egress command entry
 */

`include "mrdma_defines.svh"

package mrdma_pkg;

  // ==================================================
  // configuration, held stable for a whole operation
  // ==================================================
  typedef struct packed {
    logic [`MRDMA_DIM_W-1:0]       width;
    logic [`MRDMA_DIM_W-1:0]       height;
    logic [`MRDMA_DIM_W-1:0]       channel;
    // 0 int8, 1 int16
    logic [1:0]                    in_precision;
    // all three in 32-byte units
    logic [`MRDMA_ATOM_ADDR_W-1:0] base_addr;
    logic [`MRDMA_ATOM_ADDR_W-1:0] line_stride;
    logic [`MRDMA_ATOM_ADDR_W-1:0] surf_stride;
    logic                          perf_en;
  } mrdma_cfg_t;

  // ==================================================
  // dma read request, size on top as on the bus
  // ==================================================
  typedef struct packed {
    logic [`MRDMA_SIZE_W-1:0] size;
    logic [`MRDMA_ADDR_W-1:0] addr;
  } mrdma_dma_req_t;

  // egress command queue entry
  typedef struct packed {
    logic                    cube_end;
    logic [`MRDMA_DIM_W-1:0] size;
  } mrdma_cq_entry_t;

endpackage

// ==== src/mrdma_cmd_fsm.sv ====
/*
 * mrdma ingress command sequencer
 * idle/busy control for one operation; forms the two
 * cross-coupled valids and the common accept event
 */

`timescale 1ns/1ps

`include "mrdma_defines.svh"

module mrdma_cmd_fsm (
  input  logic nvdla_core_clk,
  input  logic nvdla_core_rstn,
  input  logic op_load,
  input  logic cube_end,
  input  logic dma_req_rdy,
  input  logic cq_rdy,
  output logic dma_req_vld,
  output logic cq_vld,
  output logic accept
);

  localparam logic ST_IDLE = 1'b0;
  localparam logic ST_BUSY = 1'b1;

  logic state;
  logic busy;
  logic done;

  // ==================================================
  // state register
  // ==================================================
  // last step of the cube leaves busy
  assign done = accept & cube_end;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      state <= ST_IDLE;
    end else begin
      // op_load wins over done
      if (op_load) begin
        state <= ST_BUSY;
      end else if (done) begin
        state <= ST_IDLE;
      end
    end
  end

  assign busy = (state == ST_BUSY);

  // ==================================================
  // paired valids
  // ==================================================
  // each side only offers when the other can take it,
  // so both transfer in the same cycle or neither does
  assign dma_req_vld = busy & cq_rdy;
  assign cq_vld      = busy & dma_req_rdy;

  // common transfer event
  assign accept = dma_req_vld & dma_req_rdy;

endmodule

// ==== src/mrdma_cube_counter.sv ====
/*
 * mrdma cube walker
 * line and channel group counters over the feature cube,
 * surface/cube end flags and the per-request size
 */

`timescale 1ns/1ps

`include "mrdma_defines.svh"

module mrdma_cube_counter (
  input  logic                     nvdla_core_clk,
  input  logic                     nvdla_core_rstn,
  input  mrdma_pkg::mrdma_cfg_t    cfg,
  input  logic                     accept,
  output logic                     surf_end,
  output logic                     cube_end,
  output logic [`MRDMA_SIZE_W-1:0] req_size
);

  logic [`MRDMA_CGRP_W-1:0] cgrp_last;
  logic [`MRDMA_CGRP_W-1:0] count_c;
  logic [`MRDMA_DIM_W-1:0]  count_h;
  logic                     pack_mode;
  logic                     is_last_c;
  logic                     is_last_h;

  // ==================================================
  // channel groups from precision
  // ==================================================
  // int8 packs 32 channels per atom, int16 packs 16
  always_comb begin
    case (cfg.in_precision)
      `MRDMA_PREC_INT8: begin
        cgrp_last = {1'b0, cfg.channel[`MRDMA_DIM_W-1:`MRDMA_ATOM_SHIFT]};
      end
      default: begin
        // int16, other codes walk the same way
        cgrp_last = cfg.channel[`MRDMA_DIM_W-1:`MRDMA_ATOM_SHIFT-1];
      end
    endcase
  end

  // 1x1 pack, whole cube in one request
  assign pack_mode = (cfg.width == '0) & (cfg.height == '0);

  // ==================================================
  // cube shape
  // ==================================================
  assign is_last_h = (count_h == cfg.height);
  assign is_last_c = (count_c == cgrp_last);

  assign surf_end = pack_mode | is_last_h;
  assign cube_end = surf_end & (pack_mode | is_last_c);

  // ==================================================
  // counters
  // ==================================================
  // channel group, wraps at cube end
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      count_c <= '0;
    end else begin
      if (accept) begin
        if (cube_end) begin
          count_c <= '0;
        end else if (surf_end) begin
          count_c <= count_c + 1'b1;
        end
      end
    end
  end

  // line within a surface
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      count_h <= '0;
    end else begin
      if (accept) begin
        if (surf_end) begin
          count_h <= '0;
        end else begin
          count_h <= count_h + 1'b1;
        end
      end
    end
  end

  // ==================================================
  // request size
  // ==================================================
  // pack mode reads every channel group at once,
  // otherwise one line of width atoms
  always_comb begin
    if (pack_mode) begin
      req_size = {{(`MRDMA_SIZE_W - `MRDMA_CGRP_W){1'b0}}, cgrp_last};
    end else begin
      req_size = {{(`MRDMA_SIZE_W - `MRDMA_DIM_W){1'b0}}, cfg.width};
    end
  end

endmodule

// ==== src/mrdma_addr_gen.sv ====
/*
 * mrdma request address generator
 * line and surface base registers stepped per accepted
 * request; output is the line base as a byte address
 */

`timescale 1ns/1ps

`include "mrdma_defines.svh"

module mrdma_addr_gen (
  input  logic                     nvdla_core_clk,
  input  logic                     nvdla_core_rstn,
  input  mrdma_pkg::mrdma_cfg_t    cfg,
  input  logic                     op_load,
  input  logic                     accept,
  input  logic                     surf_end,
  output logic [`MRDMA_ADDR_W-1:0] req_addr
);

  logic [`MRDMA_ATOM_ADDR_W-1:0] base_addr_line;
  logic [`MRDMA_ATOM_ADDR_W-1:0] base_addr_surf;
  logic [`MRDMA_ATOM_ADDR_W-1:0] next_surf;

  // start of the next channel group
  // wrap past the top of memory is not checked
  assign next_surf = base_addr_surf + cfg.surf_stride;

  // ==================================================
  // line base
  // ==================================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      base_addr_line <= '0;
    end else begin
      if (op_load) begin
        base_addr_line <= cfg.base_addr;
      end else if (accept) begin
        // new surface restarts at its first line
        if (surf_end) begin
          base_addr_line <= next_surf;
        end else begin
          base_addr_line <= base_addr_line + cfg.line_stride;
        end
      end
    end
  end

  // ==================================================
  // surface base
  // ==================================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      base_addr_surf <= '0;
    end else begin
      if (op_load) begin
        base_addr_surf <= cfg.base_addr;
      end else if (accept && surf_end) begin
        base_addr_surf <= next_surf;
      end
    end
  end

  // atom address back to bytes
  assign req_addr = {base_addr_line, {`MRDMA_ATOM_SHIFT{1'b0}}};

endmodule

// ==== src/mrdma_stall_counter.sv ====
/*
 * mrdma read stall counter
 * counts cycles where a DMA request is offered but not
 * taken; enable sampled and count cleared per operation
 */

`timescale 1ns/1ps

`include "mrdma_defines.svh"

module mrdma_stall_counter (
  input  logic                      nvdla_core_clk,
  input  logic                      nvdla_core_rstn,
  input  logic                      op_load,
  input  logic                      perf_en,
  input  logic                      dma_req_vld,
  input  logic                      dma_req_rdy,
  output logic [`MRDMA_STALL_W-1:0] stall_count
);

  logic                      cnt_en;
  logic                      stall;
  logic [`MRDMA_STALL_W-1:0] cnt;

  // request held off by the DMA side
  assign stall = dma_req_vld & ~dma_req_rdy;

  // ==================================================
  // enable, sampled once per operation
  // ==================================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cnt_en <= 1'b0;
    end else begin
      if (op_load) begin
        cnt_en <= perf_en;
      end
    end
  end

  // ==================================================
  // counter
  // ==================================================
  // clears on every op_load, even with counting off
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cnt <= '0;
    end else begin
      if (op_load) begin
        cnt <= '0;
      end else if (cnt_en && stall) begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // register value straight out
  assign stall_count = cnt;

endmodule

// ==== src/sdp_mrdma_ig.sv ====
/*
 * sdp mrdma ingress
 * walks the feature cube of one operation and issues
 * paired DMA read requests and egress queue commands,
 * plus a stall counter for performance monitoring
 */

`timescale 1ns/1ps

`include "mrdma_defines.svh"

module sdp_mrdma_ig (
  input  logic                      nvdla_core_clk,
  input  logic                      nvdla_core_rstn,
  input  logic                      op_load,
  input  mrdma_pkg::mrdma_cfg_t     cfg,
  output mrdma_pkg::mrdma_dma_req_t dma_req,
  output logic                      dma_req_vld,
  input  logic                      dma_req_rdy,
  output mrdma_pkg::mrdma_cq_entry_t cq_entry,
  output logic                      cq_vld,
  input  logic                      cq_rdy,
  output logic [`MRDMA_STALL_W-1:0] stall_count
);

  logic                     accept;
  logic                     surf_end;
  logic                     cube_end;
  logic [`MRDMA_SIZE_W-1:0] req_size;
  logic [`MRDMA_ADDR_W-1:0] req_addr;

  // ==================================================
  // sequencing
  // ==================================================
  mrdma_cmd_fsm mrdma_cmd_fsm_inst (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .cube_end        (cube_end),
    .dma_req_rdy     (dma_req_rdy),
    .cq_rdy          (cq_rdy),
    .dma_req_vld     (dma_req_vld),
    .cq_vld          (cq_vld),
    .accept          (accept)
  );

  // cube position and size
  mrdma_cube_counter mrdma_cube_counter_inst (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .cfg             (cfg),
    .accept          (accept),
    .surf_end        (surf_end),
    .cube_end        (cube_end),
    .req_size        (req_size)
  );

  // request address
  mrdma_addr_gen mrdma_addr_gen_inst (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .cfg             (cfg),
    .op_load         (op_load),
    .accept          (accept),
    .surf_end        (surf_end),
    .req_addr        (req_addr)
  );

  // perf statistic
  mrdma_stall_counter mrdma_stall_counter_inst (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .perf_en         (cfg.perf_en),
    .dma_req_vld     (dma_req_vld),
    .dma_req_rdy     (dma_req_rdy),
    .stall_count     (stall_count)
  );

  // ==================================================
  // output payloads
  // ==================================================
  assign dma_req.size = req_size;
  assign dma_req.addr = req_addr;

  // egress only needs the low size bits
  assign cq_entry.cube_end = cube_end;
  assign cq_entry.size     = req_size[`MRDMA_DIM_W-1:0];

endmodule

// ==== tb/mrdma_ig_assertions.sv ====
/*
 * mrdma ingress protocol checks
 * bound to the top level; pairing of the two outputs,
 * valids only after a load, idle out of reset and a
 * stall count that only falls on a new operation
 */

`timescale 1ns/1ps

`include "mrdma_defines.svh"

module mrdma_ig_assertions (
  input logic                      nvdla_core_clk,
  input logic                      nvdla_core_rstn,
  input logic                      op_load,
  input logic                      dma_req_vld,
  input logic                      dma_req_rdy,
  input logic                      cq_vld,
  input logic                      cq_rdy,
  input logic [`MRDMA_STALL_W-1:0] stall_count
);

  // set by the first op_load after reset
  logic seen_load;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      seen_load <= 1'b0;
    end else if (op_load) begin
      seen_load <= 1'b1;
    end
  end

  // ==================================================
  // output pairing
  // ==================================================
  paired_transfer: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (dma_req_vld && dma_req_rdy) == (cq_vld && cq_rdy)
  ) else $error("DMA request and queue entry transferred apart");

  // nothing offered before the first operation
  valid_after_load: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (dma_req_vld || cq_vld) |-> seen_load
  ) else $error("valid raised with no op_load before it");

  // ==================================================
  // reset and perf counter
  // ==================================================
  idle_after_reset: assert property (
    @(posedge nvdla_core_clk)
    $rose(nvdla_core_rstn) |-> (!dma_req_vld && !cq_vld)
  ) else $error("valid high in the first cycle out of reset");

  // only a new operation may pull the count down
  stall_no_fall: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (stall_count < $past(stall_count)) |-> $past(op_load)
  ) else $error("stall count fell without an op_load");

endmodule

// ==== tb/tb_sdp_mrdma_ig.sv ====
/*
 * testbench for the sdp mrdma ingress
 * runs INT8, INT16 and pack-mode cubes under random
 * back-pressure, checks every transfer against a model
 * of the cube walk and checks the stall counter
 */

`timescale 1ns/1ps

`include "mrdma_defines.svh"

module tb_sdp_mrdma_ig;

  localparam int OP_TIMEOUT = 2000;

  logic                       nvdla_core_clk;
  logic                       nvdla_core_rstn;
  logic                       op_load;
  mrdma_pkg::mrdma_cfg_t      cfg;
  mrdma_pkg::mrdma_dma_req_t  dma_req;
  logic                       dma_req_vld;
  logic                       dma_req_rdy;
  mrdma_pkg::mrdma_cq_entry_t cq_entry;
  logic                       cq_vld;
  logic                       cq_rdy;
  logic [`MRDMA_STALL_W-1:0]  stall_count;

  // model output, front is the next request due
  mrdma_pkg::mrdma_dma_req_t exp_req_q[$];
  logic                      exp_end_q[$];

  integer seed;
  int     exp_total;
  int     xfer_count;
  int     stall_seen;
  int     err_count;
  int     errs_before;
  int     pass_count;
  int     fail_count;
  logic   aborted;

  sdp_mrdma_ig sdp_mrdma_ig_inst (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .cfg             (cfg),
    .dma_req         (dma_req),
    .dma_req_vld     (dma_req_vld),
    .dma_req_rdy     (dma_req_rdy),
    .cq_entry        (cq_entry),
    .cq_vld          (cq_vld),
    .cq_rdy          (cq_rdy),
    .stall_count     (stall_count)
  );

  bind sdp_mrdma_ig mrdma_ig_assertions mrdma_ig_assertions_inst (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .dma_req_vld     (dma_req_vld),
    .dma_req_rdy     (dma_req_rdy),
    .cq_vld          (cq_vld),
    .cq_rdy          (cq_rdy),
    .stall_count     (stall_count)
  );

  initial begin
    nvdla_core_clk = 1'b0;
    forever #5 nvdla_core_clk = ~nvdla_core_clk;
  end

  // ==================================================
  // reference model of the cube walk
  // ==================================================
  function automatic void build_expected(input mrdma_pkg::mrdma_cfg_t c);
    mrdma_pkg::mrdma_dma_req_t r;
    int                        groups;
    int                        sum;
    int                        cg;
    int                        h;
    exp_req_q.delete();
    exp_end_q.delete();
    // last channel group index, 32 channels per atom for int8
    if (c.in_precision == `MRDMA_PREC_INT8) begin
      groups = int'(c.channel) >> 5;
    end else begin
      groups = int'(c.channel) >> 4;
    end
    if (c.width == 0 && c.height == 0) begin
      // 1x1 pack, a single request for all groups
      r.size = groups[`MRDMA_SIZE_W-1:0];
      r.addr = {c.base_addr, {`MRDMA_ATOM_SHIFT{1'b0}}};
      exp_req_q.push_back(r);
      exp_end_q.push_back(1'b1);
    end else begin
      for (cg = 0; cg <= groups; cg++) begin
        for (h = 0; h <= int'(c.height); h++) begin
          sum = int'(c.base_addr) + cg * int'(c.surf_stride) + h * int'(c.line_stride);
          r.size = '0;
          r.size[`MRDMA_DIM_W-1:0] = c.width;
          r.addr = {sum[`MRDMA_ATOM_ADDR_W-1:0], {`MRDMA_ATOM_SHIFT{1'b0}}};
          exp_req_q.push_back(r);
          exp_end_q.push_back((cg == groups) && (h == int'(c.height)));
        end
      end
    end
  endfunction

  function automatic mrdma_pkg::mrdma_cfg_t make_cfg(
    input int         w,
    input int         h,
    input int         ch,
    input logic [1:0] prec,
    input int         base,
    input int         line,
    input int         surf,
    input logic       perf
  );
    mrdma_pkg::mrdma_cfg_t c;
    c.width        = w[`MRDMA_DIM_W-1:0];
    c.height       = h[`MRDMA_DIM_W-1:0];
    c.channel      = ch[`MRDMA_DIM_W-1:0];
    c.in_precision = prec;
    c.base_addr    = base[`MRDMA_ATOM_ADDR_W-1:0];
    c.line_stride  = line[`MRDMA_ATOM_ADDR_W-1:0];
    c.surf_stride  = surf[`MRDMA_ATOM_ADDR_W-1:0];
    c.perf_en      = perf;
    return c;
  endfunction

  // ready high with pct percent chance
  function automatic logic draw_ready(input int pct);
    return ($unsigned($random(seed)) % 100) < pct;
  endfunction

  // ==================================================
  // transfer monitor
  // ==================================================
  function automatic void check_transfer();
    mrdma_pkg::mrdma_dma_req_t exp_req;
    logic                      exp_end;
    xfer_count++;
    if (exp_req_q.size() == 0) begin
      $display("unexpected request at %0t, the model had none left", $time);
      err_count++;
    end else begin
      exp_req = exp_req_q.pop_front();
      exp_end = exp_end_q.pop_front();
      assert (dma_req.addr == exp_req.addr) else begin
        $display("Mismatch dma_req.addr: got %h expected %h", dma_req.addr, exp_req.addr);
        err_count++;
      end
      assert (dma_req.size == exp_req.size) else begin
        $display("Mismatch dma_req.size: got %h expected %h", dma_req.size, exp_req.size);
        err_count++;
      end
      assert (cq_entry.size == exp_req.size[`MRDMA_DIM_W-1:0]) else begin
        $display("Mismatch cq_entry.size: got %h expected %h", cq_entry.size,
                 exp_req.size[`MRDMA_DIM_W-1:0]);
        err_count++;
      end
      assert (cq_entry.cube_end == exp_end) else begin
        $display("Mismatch cq_entry.cube_end: got %h expected %h", cq_entry.cube_end, exp_end);
        err_count++;
      end
    end
  endfunction

  // sampled at the rising edge, inputs only move on the falling one
  always @(posedge nvdla_core_clk) begin
    if (nvdla_core_rstn) begin
      assert ((dma_req_vld && dma_req_rdy) == (cq_vld && cq_rdy)) else begin
        $display("DMA request and queue entry did not transfer together at %0t", $time);
        err_count++;
      end
      if (dma_req_vld && !dma_req_rdy) begin
        stall_seen++;
      end
      if (dma_req_vld && dma_req_rdy) begin
        check_transfer();
      end
    end
  end

  // ==================================================
  // one operation from op_load to the last transfer
  // ==================================================
  task automatic run_operation(input mrdma_pkg::mrdma_cfg_t c, input int rdy_pct);
    int cycles;
    cycles = 0;
    @(negedge nvdla_core_clk);
    cfg = c;
    build_expected(c);
    exp_total  = exp_req_q.size();
    xfer_count = 0;
    stall_seen = 0;
    op_load    = 1'b1;
    @(negedge nvdla_core_clk);
    op_load = 1'b0;
    while (exp_req_q.size() != 0 && cycles < OP_TIMEOUT) begin
      dma_req_rdy = draw_ready(rdy_pct);
      cq_rdy      = draw_ready(rdy_pct);
      @(negedge nvdla_core_clk);
      cycles++;
    end
    if (exp_req_q.size() != 0) begin
      $display("timeout: %0d requests still missing after %0d cycles",
               exp_req_q.size(), cycles);
      aborted = 1'b1;
    end else begin
      // an extra request here is caught by the monitor
      dma_req_rdy = 1'b1;
      cq_rdy      = 1'b1;
      repeat (3) @(negedge nvdla_core_clk);
    end
    dma_req_rdy = 1'b0;
    cq_rdy      = 1'b0;
  endtask

  task automatic finish_test(input string name, input int errs_at_start);
    if (err_count == errs_at_start && !aborted) begin
      pass_count++;
      $display("test %s: passed", name);
    end else begin
      fail_count++;
      $display("test %s: failed", name);
    end
  endtask

  // ==================================================
  // test sequence
  // ==================================================
  initial begin
    seed            = 65;
    err_count       = 0;
    pass_count      = 0;
    fail_count      = 0;
    aborted         = 1'b0;
    exp_total       = 0;
    xfer_count      = 0;
    stall_seen      = 0;
    nvdla_core_rstn = 1'b0;
    op_load         = 1'b0;
    cfg             = '0;
    // both sides ready out of reset, a stray valid would transfer
    dma_req_rdy     = 1'b1;
    cq_rdy          = 1'b1;
    repeat (3) @(negedge nvdla_core_clk);
    nvdla_core_rstn = 1'b1;

    // 3 groups of 4 lines
    errs_before = err_count;
    run_operation(make_cfg(7, 3, 70, `MRDMA_PREC_INT8, 'h100, 'h8, 'h40, 1'b0), 75);
    finish_test("int8 cube", errs_before);

    // same channels, 5 groups, surface step per group
    if (!aborted) begin
      errs_before = err_count;
      run_operation(make_cfg(7, 3, 70, `MRDMA_PREC_INT16, 'h200, 'h10, 'h80, 1'b0), 75);
      finish_test("int16 cube", errs_before);
    end
    if (!aborted) begin
      errs_before = err_count;
      run_operation(make_cfg(0, 0, 70, `MRDMA_PREC_INT8, 'h2345, 'h8, 'h40, 1'b0), 75);
      finish_test("pack mode", errs_before);
    end

    // heavy back-pressure on both readies
    if (!aborted) begin
      errs_before = err_count;
      run_operation(make_cfg(3, 5, 40, `MRDMA_PREC_INT16, 'h4000, 'h3, 'h21, 1'b0), 50);
      assert (xfer_count == exp_total) else begin
        $display("Mismatch transfer count: got %h expected %h", xfer_count, exp_total);
        err_count++;
      end
      finish_test("back-pressure", errs_before);
    end

    // counting on, then off, the second load clears it
    if (!aborted) begin
      errs_before = err_count;
      run_operation(make_cfg(5, 2, 64, `MRDMA_PREC_INT8, 'h3000, 'h6, 'h20, 1'b1), 50);
      assert (stall_count == stall_seen) else begin
        $display("Mismatch stall_count: got %h expected %h", stall_count, stall_seen);
        err_count++;
      end
      if (!aborted) begin
        run_operation(make_cfg(5, 2, 64, `MRDMA_PREC_INT8, 'h3000, 'h6, 'h20, 1'b0), 50);
      end
      assert (stall_count == 0) else begin
        $display("Mismatch stall_count: got %h expected %h", stall_count, 0);
        err_count++;
      end
      finish_test("stall counter", errs_before);
    end

    $display("tests passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0 && err_count == 0 && !aborted) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+src
src/mrdma_pkg.sv
src/mrdma_cmd_fsm.sv
src/mrdma_cube_counter.sv
src/mrdma_addr_gen.sv
src/mrdma_stall_counter.sv
src/sdp_mrdma_ig.sv
tb/mrdma_ig_assertions.sv
tb/tb_sdp_mrdma_ig.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the mrdma ingress testbench with verilator, run it,
# and look for the pass line in its output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_sdp_mrdma_ig -f vlog.f \
  && ./obj_dir/Vtb_sdp_mrdma_ig | tee /dev/stderr | grep "^STATUS: PASS$" > /dev/null \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }
